// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_mpmc, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/Vtb_mpmc: files.f source/*.sv dv/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mpmc -f files.f

test: obj_dir/Vtb_mpmc
	-./obj_dir/Vtb_mpmc > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/mig_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mig_model (
	input  logic                            mem_ui_clk,
	input  logic                            irst,
	input  logic                            app_en,
	input  logic [2:0]                      app_cmd,
	input  logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr,
	input  logic [mpmc_pkg::DATA_W-1:0]     app_wdf_data,
	input  logic [mpmc_pkg::SEL_W-1:0]      app_wdf_mask,
	input  logic                            app_wdf_wren,
	input  logic                            app_ref_req,
	// stall and latency controls from the testbench
	input  logic                            stall_rdy,
	input  logic                            stall_wdf,
	input  logic [3:0]                      rd_lat,
	output logic                            app_rdy,
	output logic                            app_wdf_rdy,
	output logic [mpmc_pkg::DATA_W-1:0]     app_rd_data,
	output logic                            app_rd_data_valid,
	output logic                            app_rd_data_end,
	output logic                            app_ref_ack
);
	import mpmc_pkg::*;

	logic [DATA_W-1:0] mem [16];
	logic              have_cmd;
	logic [3:0]        cmd_line;
	logic              have_dat;
	logic [DATA_W-1:0] dat;
	logic [SEL_W-1:0]  dat_mask;
	logic              rd_busy;
	logic [3:0]        rd_cnt;
	logic [3:0]        rd_idx;
	logic [2:0]        ref_wait;

	assign app_rdy         = !stall_rdy;
	assign app_wdf_rdy     = !stall_wdf;
	assign app_rd_data_end = app_rd_data_valid;

	// ========================================================================
	// write path where command and data beat may arrive in either order
	// ========================================================================
	always @(posedge mem_ui_clk) begin : wr_path
		logic              c_ok;
		logic              d_ok;
		logic [3:0]        line;
		logic [DATA_W-1:0] wd;
		logic [SEL_W-1:0]  wm;
		if (irst) begin
			have_cmd = 1'b0;
			have_dat = 1'b0;
			for (int k = 0; k < 16; k++)
				mem[k] = '0;
		end else begin
			c_ok = have_cmd || (app_en && app_rdy && app_cmd == APP_CMD_WRITE);
			d_ok = have_dat || (app_wdf_wren && app_wdf_rdy);
			line = have_cmd ? cmd_line : app_addr[8:5];
			wd   = have_dat ? dat : app_wdf_data;
			wm   = have_dat ? dat_mask : app_wdf_mask;
			if (c_ok && d_ok) begin
				for (int b = 0; b < SEL_W; b++)
					if (!wm[b])
						mem[line][b*8 +: 8] = wd[b*8 +: 8];
				have_cmd = 1'b0;
				have_dat = 1'b0;
			end else begin
				have_cmd = c_ok;
				cmd_line = line;
				have_dat = d_ok;
				dat      = wd;
				dat_mask = wm;
			end
		end
	end

	// read path with a latency picked at command time
	always @(posedge mem_ui_clk) begin
		if (irst) begin
			rd_busy           <= 1'b0;
			app_rd_data_valid <= 1'b0;
			app_rd_data       <= '0;
		end else begin
			app_rd_data_valid <= 1'b0;
			if (app_en && app_rdy && app_cmd == APP_CMD_READ) begin
				rd_busy <= 1'b1;
				rd_cnt  <= rd_lat;
				rd_idx  <= app_addr[8:5];
			end else if (rd_busy) begin
				if (rd_cnt <= 4'd1) begin
					rd_busy           <= 1'b0;
					app_rd_data_valid <= 1'b1;
					app_rd_data       <= mem[rd_idx];
				end else begin
					rd_cnt <= rd_cnt - 4'd1;
				end
			end
		end
	end

	// refresh ack a few cycles after the request
	always @(posedge mem_ui_clk) begin
		if (irst || !app_ref_req) begin
			ref_wait    <= '0;
			app_ref_ack <= 1'b0;
		end else begin
			app_ref_ack <= (ref_wait == 3'd3);
			if (ref_wait != 3'd7)
				ref_wait <= ref_wait + 3'd1;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_mpmc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mpmc;
	import mpmc_pkg::*;

	localparam int ACK_TIMEOUT = 4000;
	localparam int NUM_TXN     = 200;

	logic                  mem_ui_clk;
	logic                  irst;
	logic [NUM_CH-1:0]     ch_cyc;
	logic [NUM_CH-1:0]     ch_we;
	logic [ADDR_W-1:0]     ch_adr  [NUM_CH];
	logic [SEL_W-1:0]      ch_sel  [NUM_CH];
	logic [DATA_W-1:0]     ch_data [NUM_CH];
	logic [NUM_CH-1:0]     ch_ack;
	logic [DATA_W-1:0]     ch_dat  [NUM_CH];
	logic                  app_en;
	logic [2:0]            app_cmd;
	logic [APP_ADDR_W-1:0] app_addr;
	logic [DATA_W-1:0]     app_wdf_data;
	logic [SEL_W-1:0]      app_wdf_mask;
	logic                  app_wdf_wren;
	logic                  app_wdf_end;
	logic                  app_ref_req;
	logic                  app_rdy;
	logic                  app_wdf_rdy;
	logic [DATA_W-1:0]     app_rd_data;
	logic                  app_rd_data_valid;
	logic                  app_rd_data_end;
	logic                  app_ref_ack;
	logic                  calib_complete;
	logic                  stall_rdy;
	logic                  stall_wdf;
	logic [3:0]            rd_lat;

	// scoreboard state
	logic [DATA_W-1:0]     ref_mem [16];
	logic                  out_we    [NUM_CH];
	logic [ADDR_W-1:0]     out_adr   [NUM_CH];
	logic [SEL_W-1:0]      out_sel   [NUM_CH];
	logic [DATA_W-1:0]     out_data  [NUM_CH];
	logic                  busy      [NUM_CH];
	time                   out_start [NUM_CH];
	time                   last_ack  [NUM_CH];
	logic                  acked     [NUM_CH];
	logic [32:0]           cmd_q [$];
	logic [DATA_W+SEL_W-1:0] wdf_q [$];
	logic [31:0]           rng;
	int                    cyc_cnt;
	int                    ref_mark;
	int                    ref_count;
	int                    fail_count;
	logic                  ref_req_d;
	logic                  ref_ack_seen;
	logic                  calib_d;
	logic                  fair_on;

	mpmc_top DUT (.*);

	mig_model u_mig (.*);

	initial begin
		mem_ui_clk = 1'b0;
		forever #5 mem_ui_clk = ~mem_ui_clk;
	end

	always @(posedge mem_ui_clk)
		cyc_cnt <= cyc_cnt + 1;

	// ========================================================================
	// helpers
	// ========================================================================
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [DATA_W-1:0] random_line();
		logic [DATA_W-1:0] v;
		for (int k = 0; k < DATA_W / 32; k++)
			v[k*32 +: 32] = next_rand();
		return v;
	endfunction

	// selected bytes take the new data and the rest keep the old
	function automatic logic [DATA_W-1:0] merge_line(input logic [DATA_W-1:0] old_l,
			input logic [DATA_W-1:0] new_l, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] v;
		for (int b = 0; b < SEL_W; b++)
			v[b*8 +: 8] = sel[b] ? new_l[b*8 +: 8] : old_l[b*8 +: 8];
		return v;
	endfunction

	task automatic fail_value(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		fail_count++;
		$display("ERROR: %s expected %h actual %h", name, exp, act);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic fail_text(input string msg);
		fail_count++;
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// stalls and read latency change every cycle
	always @(posedge mem_ui_clk) begin : stall_gen
		logic [31:0] r;
		r = next_rand();
		stall_rdy <= (r[1:0] == 2'd0);
		stall_wdf <= (r[3:2] == 2'd0);
		rd_lat    <= {1'b0, r[6:4]} + 4'd1;
	end

	// one request on one channel that returns after the ack and a gap
	task automatic drive_request(input int ch, input logic we, input logic [ADDR_W-1:0] adr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] data);
		int waited;
		waited       = 0;
		out_we[ch]   = we;
		out_adr[ch]  = adr;
		out_sel[ch]  = sel;
		out_data[ch] = data;
		@(posedge mem_ui_clk);
		ch_cyc[ch]  <= 1'b1;
		ch_we[ch]   <= we;
		ch_adr[ch]  <= adr;
		ch_sel[ch]  <= sel;
		ch_data[ch] <= data;
		@(negedge mem_ui_clk);
		// the request counts as waiting once cyc is seen high
		busy[ch]      = 1'b1;
		out_start[ch] = $time;
		while (!ch_ack[ch]) begin
			if (waited >= ACK_TIMEOUT)
				fail_text($sformatf("timeout waiting for ack on channel %0d", ch));
			waited++;
			@(negedge mem_ui_clk);
		end
		busy[ch] = 1'b0;
		@(posedge mem_ui_clk);
		ch_cyc[ch] <= 1'b0;
		@(posedge mem_ui_clk);
	endtask

	task automatic channel_traffic(input int ch);
		logic [31:0] r;
		logic [31:0] hi;
		for (int n = 0; n < NUM_TXN; n++) begin
			r  = next_rand();
			hi = next_rand();
			drive_request(ch, r[0], {hi[31:9], r[4:1], r[9:5]}, next_rand(),
				random_line());
		end
	endtask

	// ========================================================================
	// scoreboard checked at each ack
	// ========================================================================
	task automatic handle_ack(input int i);
		logic [32:0]             c;
		logic [DATA_W+SEL_W-1:0] w;
		logic [3:0]              line;
		if (cmd_q.size() == 0)
			fail_text("ack arrived with no accepted command");
		c    = cmd_q.pop_front();
		line = out_adr[i][8:5];
		assert (c[32:30] == (out_we[i] ? APP_CMD_WRITE : APP_CMD_READ))
			else fail_value("app_cmd", out_we[i] ? APP_CMD_WRITE : APP_CMD_READ, c[32:30]);
		assert (c[29:0] == {out_adr[i][APP_ADDR_W-1:LINE_OFS], 5'b0})
			else fail_value("app_addr", {out_adr[i][APP_ADDR_W-1:LINE_OFS], 5'b0}, c[29:0]);
		if (out_we[i]) begin
			if (wdf_q.size() == 0)
				fail_text("write acked without an accepted data beat");
			w = wdf_q.pop_front();
			assert (w[DATA_W +: SEL_W] == ~out_sel[i])
				else fail_value("app_wdf_mask", ~out_sel[i], w[DATA_W +: SEL_W]);
			assert (w[DATA_W-1:0] == out_data[i])
				else fail_value("app_wdf_data", out_data[i], w[DATA_W-1:0]);
			ref_mem[line] = merge_line(ref_mem[line], out_data[i], out_sel[i]);
		end else begin
			assert (ch_dat[i] == ref_mem[line])
				else fail_value($sformatf("ch_dat[%0d]", i), ref_mem[line], ch_dat[i]);
		end
		// a channel waiting since before our last ack must have gone first
		if (fair_on && acked[i]) begin
			for (int j = 0; j < NUM_CH; j++)
				if (j != i && busy[j] && out_start[j] < last_ack[i])
					fail_text($sformatf("channel %0d served twice while %0d waited", i, j));
		end
		last_ack[i] = $time;
		acked[i]    = 1'b1;
	endtask

	always @(negedge mem_ui_clk) begin
		if (!irst) begin
			if (!calib_complete) begin
				assert (!app_en && !app_ref_req)
					else fail_text("application activity before calibration");
			end
			assert (!(app_en && app_ref_req))
				else fail_text("app_en high while app_ref_req is high");
			if (calib_complete && !calib_d)
				ref_mark = cyc_cnt;
			if (app_ref_req && !ref_req_d) begin
				ref_mark     = cyc_cnt;
				ref_count++;
				ref_ack_seen = 1'b0;
			end
			if (app_ref_req && app_ref_ack)
				ref_ack_seen = 1'b1;
			if (!app_ref_req && ref_req_d) begin
				assert (ref_ack_seen)
					else fail_text("app_ref_req fell without app_ref_ack");
			end
			if (calib_complete && !app_ref_req) begin
				assert (cyc_cnt - ref_mark <= REFRESH_INTERVAL + 100)
					else fail_text("refresh request came too late");
			end
			ref_req_d = app_ref_req;
			calib_d   = calib_complete;
			if (app_en && app_rdy)
				cmd_q.push_back({app_cmd, app_addr});
			if (app_wdf_wren && app_wdf_rdy) begin
				assert (app_wdf_end)
					else fail_text("app_wdf_end low on a write beat");
				wdf_q.push_back({app_wdf_mask, app_wdf_data});
			end
			for (int i = 0; i < NUM_CH; i++)
				if (ch_ack[i])
					handle_ack(i);
		end
	end

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		logic [DATA_W-1:0] d;
		rng            = 32'h3aea;
		cyc_cnt        = 0;
		ref_mark       = 0;
		ref_count      = 0;
		fail_count     = 0;
		ref_req_d      = 1'b0;
		ref_ack_seen   = 1'b0;
		calib_d        = 1'b0;
		fair_on        = 1'b0;
		irst           = 1'b1;
		calib_complete = 1'b0;
		ch_cyc         = '0;
		ch_we          = '0;
		stall_rdy      = 1'b0;
		stall_wdf      = 1'b0;
		rd_lat         = 4'd1;
		for (int i = 0; i < NUM_CH; i++) begin
			ch_adr[i]  = '0;
			ch_sel[i]  = '0;
			ch_data[i] = '0;
			busy[i]    = 1'b0;
			acked[i]   = 1'b0;
		end
		for (int k = 0; k < 16; k++)
			ref_mem[k] = '0;
		repeat (16) @(posedge mem_ui_clk);
		irst <= 1'b0;

		// channel 0 requests while calibration is still running
		d = random_line();
		fork
			drive_request(0, 1'b1, 32'h0000_0040, '1, d);
		join_none
		repeat (20) @(posedge mem_ui_clk);
		calib_complete <= 1'b1;
		wait fork;
		drive_request(0, 1'b0, 32'h0000_0040, '0, '0);

		// full write then a partial merge on channel 1
		drive_request(1, 1'b1, 32'h8000_0167, '1, random_line());
		drive_request(1, 1'b1, 32'h8000_0160, 32'h0f0f_a5c3, random_line());
		drive_request(1, 1'b0, 32'h8000_0160, '0, '0);

		fair_on = 1'b1;
		fork
			channel_traffic(0);
			channel_traffic(1);
			channel_traffic(2);
			channel_traffic(3);
		join
		fair_on = 1'b0;

		if (ref_count < 2)
			fail_text("fewer than two refresh requests were seen");
		repeat (5) @(posedge mem_ui_clk);
		if (fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
source/mpmc_pkg.sv
source/mpmc_req_if.sv
source/mpmc_arbiter.sv
source/mpmc_sequencer.sv
source/mpmc_responder.sv
source/mpmc_top.sv
dv/mig_model.sv
dv/tb_mpmc.sv

// ==== source/mpmc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_arbiter (
	input  logic                          mem_ui_clk,
	input  logic                          irst,
	input  logic [mpmc_pkg::NUM_CH-1:0]   ch_cyc,
	input  logic [mpmc_pkg::NUM_CH-1:0]   ch_we,
	input  logic [mpmc_pkg::ADDR_W-1:0]   ch_adr  [mpmc_pkg::NUM_CH],
	input  logic [mpmc_pkg::SEL_W-1:0]    ch_sel  [mpmc_pkg::NUM_CH],
	input  logic [mpmc_pkg::DATA_W-1:0]   ch_data [mpmc_pkg::NUM_CH],
	mpmc_req_if.source                    rq
);
	import mpmc_pkg::*;

	held_req_t         hold [NUM_CH];
	logic [NUM_CH-1:0] full;
	logic [NUM_CH-1:0] armed;
	port_t             ptr;
	port_t             grant;
	logic              grant_ok;

	// ========================================================================
	// request holders, one entry per channel
	// ========================================================================
	for (genvar i = 0; i < NUM_CH; i++) begin : g_hold
		// payload only, no reset needed
		always_ff @(posedge mem_ui_clk) begin
			if (ch_cyc[i] && !full[i] && armed[i]) begin
				hold[i].we   <= ch_we[i];
				hold[i].adr  <= ch_adr[i];
				hold[i].sel  <= ch_sel[i];
				hold[i].data <= ch_data[i];
			end
		end

		always_ff @(posedge mem_ui_clk) begin
			if (irst) begin
				full[i]  <= 1'b0;
				armed[i] <= 1'b1;
			end else begin
				if (ch_cyc[i] && !full[i] && armed[i]) begin
					full[i]  <= 1'b1;
					armed[i] <= 1'b0;
				end else if (!ch_cyc[i]) begin
					// channel dropped cyc after its ack, ready for the next one
					armed[i] <= 1'b1;
				end
				if (rq.take && rq.port == port_t'(i))
					full[i] <= 1'b0;
			end
		end
	end

	// ========================================================================
	// round-robin grant
	// ========================================================================
	always_comb begin
		port_t idx;
		grant    = ptr;
		grant_ok = 1'b0;
		for (int k = 0; k < NUM_CH; k++) begin
			idx = ptr + port_t'(k);
			if (!grant_ok && full[idx]) begin
				grant    = idx;
				grant_ok = 1'b1;
			end
		end
	end

	// search restarts just past the last winner
	always_ff @(posedge mem_ui_clk) begin
		if (irst)
			ptr <= '0;
		else if (rq.take)
			ptr <= rq.port + port_t'(1);
	end

	assign rq.valid = grant_ok;
	assign rq.port  = grant;
	assign rq.req   = hold[grant];

endmodule

`default_nettype wire

// ==== source/mpmc_pkg.sv ====
`default_nettype none

package mpmc_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int NUM_CH     = 4;
	localparam int DATA_W     = 256;
	localparam int SEL_W      = DATA_W / 8;
	localparam int ADDR_W     = 32;
	localparam int APP_ADDR_W = 30;
	// byte offset within a 32-byte line
	localparam int LINE_OFS   = 5;

	// native application interface command codes
	localparam logic [2:0] APP_CMD_WRITE = 3'd0;
	localparam logic [2:0] APP_CMD_READ  = 3'd1;

	// refresh timing, counted in mem_ui_clk cycles
	localparam int REFRESH_INTERVAL = 512;
	localparam int REF_CNT_W        = $clog2(REFRESH_INTERVAL);

	typedef logic [1:0] port_t;

	typedef enum logic [2:0] {
		IDLE,
		REFRESH,
		CMD,
		WRITE_DATA,
		READ_WAIT,
		DONE
	} mpmc_state_t;

	// one request as captured from a channel
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] data;
	} held_req_t;

endpackage

`default_nettype wire

// ==== source/mpmc_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mpmc_req_if;
	import mpmc_pkg::*;

	// granted request, stable while valid is high
	logic      valid;
	port_t     port;
	held_req_t req;
	// single-cycle pop of the granted holder
	logic      take;

	modport source (
		output valid, port, req,
		input  take
	);

	modport sink (
		input  valid, port, req,
		output take
	);

endinterface

`default_nettype wire

// ==== source/mpmc_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_responder (
	input  logic                          mem_ui_clk,
	input  logic                          irst,
	input  logic                          wr_done,
	input  logic                          rd_done,
	input  mpmc_pkg::port_t               done_port,
	input  logic [mpmc_pkg::DATA_W-1:0]   rd_line,
	output logic [mpmc_pkg::NUM_CH-1:0]   ch_ack,
	output logic [mpmc_pkg::DATA_W-1:0]   ch_dat [mpmc_pkg::NUM_CH]
);
	import mpmc_pkg::*;

	// ========================================================================
	// per-channel ack and read data
	// ========================================================================

	// ack is a single-cycle pulse to the finishing channel
	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			ch_ack <= '0;
		end else begin
			ch_ack <= '0;
			if (wr_done || rd_done)
				ch_ack[done_port] <= 1'b1;
		end
	end

	// data holds until that channel's next read completes
	for (genvar i = 0; i < NUM_CH; i++) begin : g_dat
		always_ff @(posedge mem_ui_clk) begin
			if (rd_done && done_port == port_t'(i))
				ch_dat[i] <= rd_line;
		end
	end

endmodule

`default_nettype wire

// ==== source/mpmc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_sequencer (
	input  logic                            mem_ui_clk,
	input  logic                            irst,
	input  logic                            calib_complete,
	mpmc_req_if.sink                        rq,
	input  logic                            app_rdy,
	input  logic                            app_wdf_rdy,
	input  logic [mpmc_pkg::DATA_W-1:0]     app_rd_data,
	input  logic                            app_rd_data_valid,
	input  logic                            app_ref_ack,
	output logic                            app_en,
	output logic [2:0]                      app_cmd,
	output logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr,
	output logic [mpmc_pkg::DATA_W-1:0]     app_wdf_data,
	output logic [mpmc_pkg::SEL_W-1:0]      app_wdf_mask,
	output logic                            app_wdf_wren,
	output logic                            app_wdf_end,
	output logic                            app_ref_req,
	output logic                            wr_done,
	output logic                            rd_done,
	output mpmc_pkg::port_t                 done_port,
	output logic [mpmc_pkg::DATA_W-1:0]     rd_line
);
	import mpmc_pkg::*;

	mpmc_state_t          state;
	held_req_t            cur;
	port_t                cur_port;
	logic                 cmd_acc;
	logic                 wdf_acc;
	logic                 cmd_fire;
	logic                 wdf_fire;
	logic                 cmd_ok;
	logic                 wdf_ok;
	logic [REF_CNT_W-1:0] ref_cnt;
	logic                 ref_pend;
	logic                 rd_valid_r;
	logic [ADDR_W-1:0]    line_adr;

	// pop the granted holder only when no refresh is waiting
	assign rq.take = (state == IDLE) && calib_complete && !ref_pend && rq.valid;

	always_ff @(posedge mem_ui_clk) begin
		if (rq.take) begin
			cur      <= rq.req;
			cur_port <= rq.port;
		end
	end

	// ========================================================================
	// application interface outputs
	// ========================================================================
	assign line_adr     = {cur.adr[ADDR_W-1:LINE_OFS], {LINE_OFS{1'b0}}};
	assign app_addr     = line_adr[APP_ADDR_W-1:0];
	assign app_cmd      = cur.we ? APP_CMD_WRITE : APP_CMD_READ;
	assign app_wdf_data = cur.data;
	// mask bit set means byte lane is left alone
	assign app_wdf_mask = ~cur.sel;

	assign app_en       = (state == CMD) && !cmd_acc;
	assign app_wdf_wren = ((state == CMD) || (state == WRITE_DATA)) && cur.we && !wdf_acc;
	assign app_wdf_end  = app_wdf_wren;

	assign cmd_fire = app_en && app_rdy;
	assign wdf_fire = app_wdf_wren && app_wdf_rdy;
	assign cmd_ok   = cmd_acc || cmd_fire;
	assign wdf_ok   = wdf_acc || wdf_fire;

	assign wr_done   = (state == DONE) && cur.we;
	assign rd_done   = (state == DONE) && !cur.we;
	assign done_port = cur_port;

	// ========================================================================
	// main FSM
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			state       <= IDLE;
			cmd_acc     <= 1'b0;
			wdf_acc     <= 1'b0;
			app_ref_req <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				cmd_acc <= 1'b0;
				wdf_acc <= 1'b0;
				if (calib_complete) begin
					if (ref_pend)
						state <= REFRESH;
					else if (rq.valid)
						state <= CMD;
				end
			end
			REFRESH: begin
				// request goes up one cycle in, drops on the ack
				if (app_ref_req && app_ref_ack) begin
					app_ref_req <= 1'b0;
					state       <= IDLE;
				end else begin
					app_ref_req <= 1'b1;
				end
			end
			CMD: begin
				if (cmd_fire)
					cmd_acc <= 1'b1;
				if (wdf_fire)
					wdf_acc <= 1'b1;
				if (!cur.we) begin
					if (cmd_fire)
						state <= READ_WAIT;
				end else if (cmd_ok && wdf_ok) begin
					state <= DONE;
				end else if (cmd_ok) begin
					state <= WRITE_DATA;
				end
			end
			WRITE_DATA: begin
				// command is in, still waiting on the data beat
				if (wdf_fire) begin
					wdf_acc <= 1'b1;
					state   <= DONE;
				end
			end
			READ_WAIT: begin
				if (rd_valid_r)
					state <= DONE;
			end
			DONE: begin
				state <= IDLE;
			end
			default: begin
				state <= IDLE;
			end
			endcase
		end
	end

	// ========================================================================
	// refresh interval
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (irst || !calib_complete) begin
			ref_cnt  <= '0;
			ref_pend <= 1'b0;
		end else begin
			if (ref_cnt == REF_CNT_W'(REFRESH_INTERVAL - 1))
				ref_cnt <= '0;
			else
				ref_cnt <= ref_cnt + 1'b1;
			// first pending refresh comes right at calibration
			if (ref_cnt == '0)
				ref_pend <= 1'b1;
			else if (state == IDLE && ref_pend)
				ref_pend <= 1'b0;
		end
	end

	// read return, one beat per line
	always_ff @(posedge mem_ui_clk) begin
		if (irst)
			rd_valid_r <= 1'b0;
		else
			rd_valid_r <= app_rd_data_valid;
	end

	always_ff @(posedge mem_ui_clk) begin
		if (app_rd_data_valid)
			rd_line <= app_rd_data;
	end

endmodule

`default_nettype wire

// ==== source/mpmc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_top (
	input  logic                            mem_ui_clk,
	input  logic                            irst,

	// channel side
	input  logic [mpmc_pkg::NUM_CH-1:0]     ch_cyc,
	input  logic [mpmc_pkg::NUM_CH-1:0]     ch_we,
	input  logic [mpmc_pkg::ADDR_W-1:0]     ch_adr  [mpmc_pkg::NUM_CH],
	input  logic [mpmc_pkg::SEL_W-1:0]      ch_sel  [mpmc_pkg::NUM_CH],
	input  logic [mpmc_pkg::DATA_W-1:0]     ch_data [mpmc_pkg::NUM_CH],
	output logic [mpmc_pkg::NUM_CH-1:0]     ch_ack,
	output logic [mpmc_pkg::DATA_W-1:0]     ch_dat  [mpmc_pkg::NUM_CH],

	// DDR controller application interface
	output logic                            app_en,
	output logic [2:0]                      app_cmd,
	output logic [mpmc_pkg::APP_ADDR_W-1:0] app_addr,
	output logic [mpmc_pkg::DATA_W-1:0]     app_wdf_data,
	output logic [mpmc_pkg::SEL_W-1:0]      app_wdf_mask,
	output logic                            app_wdf_wren,
	output logic                            app_wdf_end,
	output logic                            app_ref_req,
	input  logic                            app_rdy,
	input  logic                            app_wdf_rdy,
	input  logic [mpmc_pkg::DATA_W-1:0]     app_rd_data,
	input  logic                            app_rd_data_valid,
	// single-beat lines, end marker carries nothing extra
	input  logic                            app_rd_data_end,
	input  logic                            app_ref_ack,
	input  logic                            calib_complete
);
	import mpmc_pkg::*;

	logic              wr_done;
	logic              rd_done;
	port_t             done_port;
	logic [DATA_W-1:0] rd_line;

	mpmc_req_if rq ();

	mpmc_arbiter u_arbiter (
		.mem_ui_clk (mem_ui_clk),
		.irst       (irst),
		.ch_cyc     (ch_cyc),
		.ch_we      (ch_we),
		.ch_adr     (ch_adr),
		.ch_sel     (ch_sel),
		.ch_data    (ch_data),
		.rq         (rq.source)
	);

	mpmc_sequencer u_sequencer (
		.mem_ui_clk        (mem_ui_clk),
		.irst              (irst),
		.calib_complete    (calib_complete),
		.rq                (rq.sink),
		.app_rdy           (app_rdy),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.app_ref_ack       (app_ref_ack),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask      (app_wdf_mask),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_ref_req       (app_ref_req),
		.wr_done           (wr_done),
		.rd_done           (rd_done),
		.done_port         (done_port),
		.rd_line           (rd_line)
	);

	mpmc_responder u_responder (
		.mem_ui_clk (mem_ui_clk),
		.irst       (irst),
		.wr_done    (wr_done),
		.rd_done    (rd_done),
		.done_port  (done_port),
		.rd_line    (rd_line),
		.ch_ack     (ch_ack),
		.ch_dat     (ch_dat)
	);

endmodule

`default_nettype wire
